// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the CD drive link testbench with Verilator
# Nonzero exit when the build fails or the log shows a failing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cdd_link_tb \
	-o cdd_link_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cdd_link_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

// ==== sim/cdd_link_asserts.sv ====
// Protocol assertions on the CD drive link top level
// Bound to cdd_link_top, checked on clk_sys outside reset

`timescale 1ns/1ps
`include "cdd_defines.svh"

module cdd_link_asserts (
	input logic clk_sys,
	input logic reset,
	input logic comclk,
	input logic cdata,
	input logic comreq_n,
	input logic cmd_toggle,
	input logic cdc_wr
);
	localparam int RUN_W = $clog2(`CDC_WR_HOLD + 2);

	logic [RUN_W-1:0] wr_run;

	// Cycles the current strobe has been high, saturating
	always_ff @(posedge clk_sys) begin
		if (reset || !cdc_wr) begin
			wr_run <= '0;
		end else if (wr_run != '1) begin
			wr_run <= wr_run + RUN_W'(1);
		end
	end

	strobe_not_long: assert property (@(posedge clk_sys) disable iff (reset)
		cdc_wr |-> wr_run < RUN_W'(`CDC_WR_HOLD))
		else $error("cdc_wr high for more than %0d cycles", `CDC_WR_HOLD);

	strobe_not_short: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(cdc_wr) |-> wr_run == RUN_W'(`CDC_WR_HOLD))
		else $error("cdc_wr pulse shorter than %0d cycles", `CDC_WR_HOLD);

	// Subsystem samples cdata while comclk is high
	cdata_stable: assert property (@(posedge clk_sys) disable iff (reset)
		comclk && $past(comclk) |-> $stable(cdata))
		else $error("cdata changed while comclk high");

	toggle_no_req: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(cmd_toggle) |-> comreq_n)
		else $error("cmd_toggle changed while comreq_n low");

endmodule

bind cdd_link_top cdd_link_asserts u_link_asserts (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.comclk    (comclk),
	.cdata     (cdata),
	.comreq_n  (comreq_n),
	.cmd_toggle(cmd_toggle),
	.cdc_wr    (cdc_wr)
);

// ==== sim/cdd_link_tb.sv ====
// Testbench for cdd_link_top with a model of the CD subsystem serial side
// comclk phases last 3 clk_sys cycles; one exchange is about 12k cycles
// because of the inter-byte delay

`timescale 1ns/1ps
`include "cdd_defines.svh"

module cdd_link_tb;
	import cdd_pkg::*;

	localparam int NBYTES      = `CDD_FRAME_BYTES;
	localparam int REQ_TIMEOUT = 2000;

	logic        clk_sys;
	logic        reset;
	cdd_frame_t  stat_frame;
	logic        stat_toggle;
	cdd_frame_t  cmd_frame;
	logic        cmd_toggle;
	logic        comclk;
	logic        hdata;
	logic        cdata;
	logic        comreq_n;
	logic        comsync_n;
	logic        dl_active;
	logic        dl_wr;
	cdc_word_u   dl_data;
	logic [15:0] cdc_data;
	logic        cdc_wr;
	logic        cdc_speed;
	logic        cdc_audio;

	integer      seed;
	int          errors;
	int          tests_run;
	int          toggle_count;
	int          pulse_count;
	logic        toggle_prev;
	logic        wr_prev;
	logic [15:0] exp_word;
	logic [15:0] exp_q[$];
	logic [7:0]  cmd_bytes[NBYTES];
	logic [7:0]  got_stat[NBYTES];

	cdd_link_top dut (.*);

	always #2 clk_sys = ~clk_sys;

	// Status byte k as it appears on cdata in LSB-first order
	function automatic logic [7:0] serial_stat_byte(input logic [95:0] flat, input int k);
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i] = flat[k*8 + i];
		end
		return b;
	endfunction

	// Host frame built from the bytes the subsystem sent with byte 0 low
	function automatic logic [95:0] frame_from_cmd_bytes();
		logic [95:0] f;
		for (int k = 0; k < NBYTES; k++) begin
			f[k*8 +: 8] = cmd_bytes[k];
		end
		return f;
	endfunction

	function automatic logic [15:0] swap_bytes(input logic [15:0] w);
		return {w[7:0], w[15:8]};
	endfunction

	task automatic report_mismatch(input string sig, input logic [95:0] got,
			input logic [95:0] exp);
		$display("ERR %s: got %0h expected %0h", sig, got, exp);
		errors++;
	endtask

	task automatic log_test(input string name, input int errs_before);
		tests_run++;
		$display("test %s done, %0d errors", name, errors - errs_before);
	endtask

	// Count cmd_toggle flips
	always @(negedge clk_sys) begin
		if (reset) begin
			toggle_prev = 1'b0;
		end else if (cmd_toggle !== toggle_prev) begin
			toggle_prev = cmd_toggle;
			toggle_count++;
		end
	end

	// Compare each cdc_wr pulse with the next expected word
	always @(negedge clk_sys) begin
		if (reset) begin
			wr_prev = 1'b0;
		end else begin
			if (cdc_wr && !wr_prev) begin
				pulse_count++;
				if (exp_q.size() == 0) begin
					$display("cdc_wr pulse with no data word pending");
					errors++;
				end else begin
					exp_word = exp_q.pop_front();
					if (cdc_data !== exp_word) begin
						report_mismatch("cdc_data", 96'(cdc_data), 96'(exp_word));
					end
				end
			end
			wr_prev = cdc_wr;
		end
	end

	// CD subsystem side of one exchange
	task automatic cd_exchange(output bit ok);
		int wait_cnt;
		ok = 1'b1;
		for (int k = 0; k < NBYTES; k++) begin
			wait_cnt = 0;
			while (comreq_n !== 1'b0 && wait_cnt < REQ_TIMEOUT) begin
				@(negedge clk_sys);
				wait_cnt++;
			end
			if (comreq_n !== 1'b0) begin
				$display("timed out waiting for comreq_n on byte %0d", k);
				errors++;
				ok = 1'b0;
				break;
			end
			if (k == 0 && comsync_n !== 1'b0) begin
				report_mismatch("comsync_n", 96'(comsync_n), 96'(0));
			end
			for (int i = 0; i < 8; i++) begin
				comclk = 1'b0;
				hdata  = cmd_bytes[k][i];
				repeat (3) @(negedge clk_sys);
				got_stat[k][i] = cdata;
				comclk = 1'b1;
				repeat (3) @(negedge clk_sys);
			end
		end
	endtask

	task automatic run_exchange(input string name, input int exp_toggles);
		int          errs_before;
		int          wait_cnt;
		bit          ok;
		logic        old_toggle;
		logic [95:0] sent_stat;
		errs_before = errors;
		sent_stat = {$random(seed), $random(seed), $random(seed)};
		for (int k = 0; k < NBYTES; k++) begin
			cmd_bytes[k] = 8'($random(seed));
		end
		old_toggle  = cmd_toggle;
		stat_frame  = sent_stat;
		stat_toggle = ~stat_toggle;
		cd_exchange(ok);
		if (ok) begin
			for (int k = 0; k < NBYTES; k++) begin
				if (got_stat[k] !== serial_stat_byte(sent_stat, k)) begin
					report_mismatch($sformatf("cdata byte %0d", k), 96'(got_stat[k]),
						96'(serial_stat_byte(sent_stat, k)));
				end
			end
			wait_cnt = 0;
			while (cmd_toggle === old_toggle && wait_cnt < 100) begin
				@(negedge clk_sys);
				wait_cnt++;
			end
			if (cmd_toggle === old_toggle) begin
				$display("timed out waiting for cmd_toggle to flip");
				errors++;
			end else if (cmd_frame !== frame_from_cmd_bytes()) begin
				report_mismatch("cmd_frame", cmd_frame, frame_from_cmd_bytes());
			end
			@(negedge clk_sys);
			if (toggle_count != exp_toggles) begin
				report_mismatch("cmd_toggle flips", 96'(toggle_count), 96'(exp_toggles));
			end
		end
		log_test(name, errs_before);
	endtask

	task automatic write_word(input logic [15:0] w);
		dl_data.raw = w;
		dl_wr       = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	initial begin
		int          errs_before;
		int          pulses_before;
		int          wait_cnt;
		logic [15:0] w;
		seed         = 32'h92ef;
		errors       = 0;
		tests_run    = 0;
		toggle_count = 0;
		pulse_count  = 0;
		clk_sys      = 1'b0;
		reset        = 1'b1;
		stat_frame   = '0;
		stat_toggle  = 1'b0;
		comclk       = 1'b1;
		hdata        = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_data.raw  = 16'h0000;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		errs_before = errors;
		if (comreq_n !== 1'b1) report_mismatch("comreq_n", 96'(comreq_n), 96'(1));
		if (comsync_n !== 1'b1) report_mismatch("comsync_n", 96'(comsync_n), 96'(1));
		if (cdc_wr !== 1'b0) report_mismatch("cdc_wr", 96'(cdc_wr), 96'(0));
		if (cmd_toggle !== 1'b0) report_mismatch("cmd_toggle", 96'(cmd_toggle), 96'(0));
		if (cdata !== 1'b0) report_mismatch("cdata", 96'(cdata), 96'(0));
		if (cmd_frame !== '0) report_mismatch("cmd_frame", cmd_frame, 96'(0));
		log_test("reset_values", errs_before);

		run_exchange("exchange_1", 1);
		run_exchange("exchange_2", 2);

		// First word of a download carries the mode bits
		errs_before   = errors;
		pulses_before = pulse_count;
		w             = 16'($random(seed));
		dl_active     = 1'b1;
		write_word(w);
		repeat (8) @(negedge clk_sys);
		if (cdc_speed !== w[0]) report_mismatch("cdc_speed", 96'(cdc_speed), 96'(w[0]));
		if (cdc_audio !== w[1]) report_mismatch("cdc_audio", 96'(cdc_audio), 96'(w[1]));
		if (pulse_count != pulses_before) begin
			$display("mode word produced a cdc_wr pulse");
			errors++;
		end
		log_test("mode_word", errs_before);

		errs_before   = errors;
		pulses_before = pulse_count;
		for (int n = 0; n < 10; n++) begin
			w = 16'($random(seed));
			exp_q.push_back(swap_bytes(w));
			write_word(w);
			repeat (7) @(negedge clk_sys);
		end
		wait_cnt = 0;
		while ((exp_q.size() != 0 || cdc_wr) && wait_cnt < 50) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (exp_q.size() != 0) begin
			$display("timed out with %0d data words never strobed", exp_q.size());
			errors++;
		end
		if (pulse_count - pulses_before != 10) begin
			report_mismatch("cdc_wr pulses", 96'(pulse_count - pulses_before), 96'(10));
		end
		dl_active = 1'b0;
		log_test("data_words", errs_before);

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/cdc_sector_feed.sv ====
// Sector data feed from a CD-data download
// First word of a download carries speed (bit 0) and audio (bit 1)
// No back-pressure, writes during a strobe are dropped

`timescale 1ns/1ps
`include "cdd_defines.svh"

module cdc_sector_feed (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               dl_active,
	input  logic               dl_wr,
	input  cdd_pkg::cdc_word_u dl_data,
	output logic [15:0]        cdc_data,
	output logic               cdc_wr,
	output logic               cdc_speed,
	output logic               cdc_audio
);
	localparam int HOLD_W = $clog2(`CDC_WR_HOLD + 1);

	typedef enum logic [1:0] {
		ST_WAIT_MODE,
		ST_IDLE,
		ST_STROBE
	} feed_state_t;

	feed_state_t       state;
	logic [HOLD_W-1:0] hold_cnt;
	logic              wr_req;

	assign wr_req = dl_active & dl_wr;

	// Byte-swapped data word, latched with each accepted write
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && wr_req) begin
			cdc_data <= {dl_data.bytes.lo, dl_data.bytes.hi};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= ST_WAIT_MODE;
			hold_cnt  <= '0;
			cdc_wr    <= 1'b0;
			cdc_speed <= 1'b0;
			cdc_audio <= 1'b0;
		end else begin
			case (state)
				ST_WAIT_MODE: begin
					if (wr_req) begin
						cdc_speed <= dl_data.mode.speed;
						cdc_audio <= dl_data.mode.audio;
						state     <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					if (!dl_active) begin
						state <= ST_WAIT_MODE;
					end else if (dl_wr) begin
						cdc_wr   <= 1'b1;
						hold_cnt <= HOLD_W'(`CDC_WR_HOLD - 1);
						state    <= ST_STROBE;
					end
				end
				ST_STROBE: begin
					// Strobe always runs its full length
					if (hold_cnt == '0) begin
						cdc_wr <= 1'b0;
						state  <= ST_IDLE;
					end else begin
						hold_cnt <= hold_cnt - 1'b1;
					end
				end
				default: state <= ST_WAIT_MODE;
			endcase
		end
	end

endmodule

// ==== verilog/cdd_defines.svh ====
// Protocol constants for the CD drive link
// Values follow the CD subsystem's timing and are not meant to be tuned
// The frame length also sets the width of the frame type in cdd_pkg

`ifndef CDD_DEFINES_SVH
`define CDD_DEFINES_SVH

//////////////////////////////
// Status and command frames
//////////////////////////////

// Bytes per frame, both directions
`define CDD_FRAME_BYTES 12

// Countdown after a host toggle before the exchange starts
`define CDD_START_WAIT 15

// Idle cycles between one byte and the next request
`define CDD_NEXT_DELAY 1023

//////////////////////////////
// Sector data feed
//////////////////////////////

// Cycles each data strobe stays high
`define CDC_WR_HOLD 4

`endif

// ==== verilog/cdd_frame_regs.sv ====
// Status and command frame registers of the CD drive link
// The host frame must stay stable from its toggle until cmd_toggle answers
// A new host toggle mid-exchange restarts the countdown and the exchange

`timescale 1ns/1ps
`include "cdd_defines.svh"

module cdd_frame_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cdd_pkg::cdd_frame_t    stat_frame,
	input  logic                   stat_toggle,
	input  cdd_pkg::cdd_byte_idx_t byte_idx,
	input  logic [7:0]             cmd_byte,
	input  logic                   cmd_we,
	input  logic                   frame_done,
	output logic [7:0]             stat_byte,
	output logic                   xfer_start,
	output cdd_pkg::cdd_frame_t    cmd_frame,
	output logic                   cmd_toggle
);
	import cdd_pkg::*;

	localparam int START_W = $clog2(`CDD_START_WAIT + 1);

	logic               stat_toggle_q;
	logic               stat_edge;
	logic               start_run;
	logic [START_W-1:0] start_cnt;
	logic               idx_ok;
	cdd_frame_t         stat_q;
	cdd_frame_t         cmd_work;

	assign stat_edge = stat_toggle ^ stat_toggle_q;
	assign idx_ok    = byte_idx < cdd_byte_idx_t'(`CDD_FRAME_BYTES);

	// Status byte for the link, zero past the end of the frame
	assign stat_byte = idx_ok ? stat_q[byte_idx] : 8'h00;

	//////////////////////////////
	// Host toggle and start countdown
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stat_toggle_q <= 1'b0;
			stat_q        <= '0;
			start_run     <= 1'b0;
			start_cnt     <= '0;
			xfer_start    <= 1'b0;
		end else begin
			stat_toggle_q <= stat_toggle;
			xfer_start    <= 1'b0;
			if (stat_edge) begin
				// Latch the frame and (re)arm the countdown
				stat_q    <= stat_frame;
				start_run <= 1'b1;
				start_cnt <= START_W'(`CDD_START_WAIT);
			end else if (start_run) begin
				start_cnt <= start_cnt - 1'b1;
				if (start_cnt == START_W'(1)) begin
					start_run  <= 1'b0;
					xfer_start <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Command frame collection
	//////////////////////////////

	// Bytes land here one by one
	always_ff @(posedge clk_sys) begin
		if (cmd_we && idx_ok) begin
			cmd_work[byte_idx] <= cmd_byte;
		end
	end

	// Host copy only changes once the whole frame is in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_frame  <= '0;
			cmd_toggle <= 1'b0;
		end else if (frame_done) begin
			cmd_frame  <= cmd_work;
			cmd_toggle <= ~cmd_toggle;
		end
	end

endmodule

// ==== verilog/cdd_link_top.sv ====
// CD drive link, status/command frame exchange plus sector data feed
// Host side uses a toggle per frame in each direction
// All ports are on clk_sys; comclk and hdata must already be synchronous

`timescale 1ns/1ps

module cdd_link_top (
	input  logic                clk_sys,
	input  logic                reset,
	// Host frame exchange
	input  cdd_pkg::cdd_frame_t stat_frame,
	input  logic                stat_toggle,
	output cdd_pkg::cdd_frame_t cmd_frame,
	output logic                cmd_toggle,
	// CD subsystem serial port
	input  logic                comclk,
	input  logic                hdata,
	output logic                cdata,
	output logic                comreq_n,
	output logic                comsync_n,
	// Sector download
	input  logic                dl_active,
	input  logic                dl_wr,
	input  cdd_pkg::cdc_word_u  dl_data,
	output logic [15:0]         cdc_data,
	output logic                cdc_wr,
	output logic                cdc_speed,
	output logic                cdc_audio
);
	import cdd_pkg::*;

	cdd_byte_idx_t byte_idx;
	logic [7:0]    stat_byte;
	logic [7:0]    cmd_byte;
	logic          xfer_start;
	logic          cmd_we;
	logic          frame_done;

	cdd_frame_regs u_frame_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.stat_frame (stat_frame),
		.stat_toggle(stat_toggle),
		.byte_idx   (byte_idx),
		.cmd_byte   (cmd_byte),
		.cmd_we     (cmd_we),
		.frame_done (frame_done),
		.stat_byte  (stat_byte),
		.xfer_start (xfer_start),
		.cmd_frame  (cmd_frame),
		.cmd_toggle (cmd_toggle)
	);

	cdd_serial_link u_serial_link (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.xfer_start(xfer_start),
		.stat_byte (stat_byte),
		.comclk    (comclk),
		.hdata     (hdata),
		.byte_idx  (byte_idx),
		.cmd_byte  (cmd_byte),
		.cmd_we    (cmd_we),
		.frame_done(frame_done),
		.cdata     (cdata),
		.comreq_n  (comreq_n),
		.comsync_n (comsync_n)
	);

	cdc_sector_feed u_sector_feed (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_active(dl_active),
		.dl_wr    (dl_wr),
		.dl_data  (dl_data),
		.cdc_data (cdc_data),
		.cdc_wr   (cdc_wr),
		.cdc_speed(cdc_speed),
		.cdc_audio(cdc_audio)
	);

endmodule

// ==== verilog/cdd_pkg.sv ====
// Types shared by the CD drive link blocks
// Frame byte 0 sits in the low bits and goes out first

`include "cdd_defines.svh"

package cdd_pkg;

	// One status or command frame
	typedef logic [`CDD_FRAME_BYTES-1:0][7:0] cdd_frame_t;

	// Byte position inside a frame
	typedef logic [3:0] cdd_byte_idx_t;

	// One download word, decoded either as mode bits or as two bytes
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [13:0] unused;
			logic        audio;
			logic        speed;
		} mode;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} cdc_word_u;

endpackage

// ==== verilog/cdd_serial_link.sv ====
// Bit-serial byte exchange with the CD subsystem
// comclk and hdata are taken as synchronous to clk_sys, with each comclk
// phase lasting at least two clk_sys cycles
// Bits travel LSB first; comsync_n marks only the first byte of a frame

`timescale 1ns/1ps
`include "cdd_defines.svh"

module cdd_serial_link (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   xfer_start,
	input  logic [7:0]             stat_byte,
	input  logic                   comclk,
	input  logic                   hdata,
	output cdd_pkg::cdd_byte_idx_t byte_idx,
	output logic [7:0]             cmd_byte,
	output logic                   cmd_we,
	output logic                   frame_done,
	output logic                   cdata,
	output logic                   comreq_n,
	output logic                   comsync_n
);
	import cdd_pkg::*;

	localparam int DLY_W = $clog2(`CDD_NEXT_DELAY + 1);
	localparam cdd_byte_idx_t LAST_IDX = cdd_byte_idx_t'(`CDD_FRAME_BYTES - 1);

	logic             comclk_q;
	logic             active;
	logic             fall_en;
	logic             rise_en;
	logic [2:0]       bit_cnt;
	logic [DLY_W-1:0] delay_cnt;
	logic             req_next;
	logic [7:0]       tx_shift;
	logic [7:0]       rx_shift;

	// comclk edges, only while a frame is in progress
	assign fall_en = active & comclk_q & ~comclk;
	assign rise_en = active & ~comclk_q & comclk;

	assign cmd_byte = rx_shift;

	//////////////////////////////
	// Shift registers
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		// Byte index is already current when the request goes out
		if (req_next) begin
			tx_shift <= stat_byte;
		end else if (fall_en) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
		if (rise_en) begin
			rx_shift <= {hdata, rx_shift[7:1]};
		end
	end

	//////////////////////////////
	// Handshake and byte sequencing
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_q   <= 1'b0;
			active     <= 1'b0;
			bit_cnt    <= '0;
			byte_idx   <= '0;
			delay_cnt  <= '0;
			req_next   <= 1'b0;
			cmd_we     <= 1'b0;
			frame_done <= 1'b0;
			cdata      <= 1'b0;
			comreq_n   <= 1'b1;
			comsync_n  <= 1'b1;
		end else begin
			comclk_q   <= comclk;
			req_next   <= 1'b0;
			cmd_we     <= 1'b0;
			frame_done <= 1'b0;
			if (xfer_start) begin
				// Start or restart at byte 0
				active    <= 1'b1;
				bit_cnt   <= '0;
				byte_idx  <= '0;
				delay_cnt <= '0;
				comsync_n <= 1'b0;
				comreq_n  <= 1'b1;
				req_next  <= 1'b1;
			end else begin
				if (req_next) begin
					comreq_n <= 1'b0;
				end
				if (fall_en) begin
					cdata <= tx_shift[0];
				end
				if (rise_en) begin
					comreq_n <= 1'b1;
					bit_cnt  <= bit_cnt + 1'b1;
					cmd_we   <= (bit_cnt == 3'd7);
				end
				// Byte complete, stored this cycle at byte_idx
				if (cmd_we) begin
					comsync_n <= 1'b1;
					if (byte_idx == LAST_IDX) begin
						active     <= 1'b0;
						frame_done <= 1'b1;
					end else begin
						byte_idx  <= byte_idx + 1'b1;
						delay_cnt <= DLY_W'(`CDD_NEXT_DELAY);
					end
				end
				// Gap before the next request
				if (delay_cnt != '0) begin
					delay_cnt <= delay_cnt - 1'b1;
					req_next  <= (delay_cnt == DLY_W'(1));
				end
			end
		end
	end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/cdd_pkg.sv
verilog/cdd_frame_regs.sv
verilog/cdd_serial_link.sv
verilog/cdc_sector_feed.sv
verilog/cdd_link_top.sv
sim/cdd_link_asserts.sv
sim/cdd_link_tb.sv
